/* verilog/rvCorePkg.sv */
`default_nettype none

package rvCorePkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;

    // 000-I 001-U 010-S 011-B 100-J
    typedef enum logic [2:0] {
        immI = 3'b000,
        immU = 3'b001,
        immS = 3'b010,
        immB = 3'b011,
        immJ = 3'b100
    } immSelT;

    typedef enum logic [1:0] {
        aluAdd   = 2'b00,
        aluSub   = 2'b01,
        aluPassB = 2'b10,
        aluEq    = 2'b11
    } aluOpT;

    typedef enum logic [1:0] {
        bFromReg = 2'b00,
        bFromImm = 2'b01,
        bFour    = 2'b10
    } aluBSelT;

    typedef enum logic [2:0] {
        brNone = 3'b000,
        brJal  = 3'b001,
        brJalr = 3'b010,
        brEq   = 3'b011,
        brNe   = 3'b100
    } branchT;

    typedef struct packed {
        logic    regWrite;
        immSelT  immSel;
        logic    aluASel;   // 1-pc 0-rs1
        aluBSelT aluBSel;
        aluOpT   aluOp;
        branchT  branch;
    } ctrlT;

    typedef struct packed {
        logic    valid;
        regAddrT rd;
        wordT    data;
    } wbT;

endpackage

`default_nettype wire

/* verilog/instDecoder.sv */
`default_nettype none

module instDecoder import rvCorePkg::*; (
    input  wire logic clk,
    input  wire logic rstN,
    input  wire wordT instr,
    output ctrlT      ctrl,
    output logic      regWe,
    output logic      halt
);

    typedef enum logic {
        running,
        halted
    } stateT;

    stateT state;
    logic [4:0] opKey;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic isEbreak;

    assign opKey  = instr[6:2];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign isEbreak = (instr == 32'h0010_0073);

    always_comb begin
        // unknown opcodes fall through as a no-op
        ctrl = '{regWrite: 1'b0, immSel: immI, aluASel: 1'b0,
                 aluBSel: bFromReg, aluOp: aluAdd, branch: brNone};
        case (opKey)
            5'b01101: begin  // lui
                ctrl.regWrite = 1'b1;
                ctrl.immSel   = immU;
                ctrl.aluBSel  = bFromImm;
                ctrl.aluOp    = aluPassB;
            end
            5'b00101: begin  // auipc
                ctrl.regWrite = 1'b1;
                ctrl.immSel   = immU;
                ctrl.aluASel  = 1'b1;
                ctrl.aluBSel  = bFromImm;
            end
            5'b11011: begin  // jal
                ctrl.regWrite = 1'b1;
                ctrl.immSel   = immJ;
                ctrl.aluASel  = 1'b1;
                ctrl.aluBSel  = bFour;
                ctrl.branch   = brJal;
            end
            5'b11001: begin
                if (funct3 == 3'b000) begin  // jalr
                    ctrl.regWrite = 1'b1;
                    ctrl.aluASel  = 1'b1;
                    ctrl.aluBSel  = bFour;
                    ctrl.branch   = brJalr;
                end
            end
            5'b00100: begin
                if (funct3 == 3'b000) begin  // addi
                    ctrl.regWrite = 1'b1;
                    ctrl.aluBSel  = bFromImm;
                end
            end
            5'b01100: begin
                if (funct3 == 3'b000 && funct7 == 7'b000_0000) begin
                    ctrl.regWrite = 1'b1;  // add
                end else if (funct3 == 3'b000 && funct7 == 7'b010_0000) begin
                    ctrl.regWrite = 1'b1;  // sub
                    ctrl.aluOp    = aluSub;
                end
            end
            5'b11000: begin
                ctrl.immSel = immB;
                ctrl.aluOp  = aluEq;
                if (funct3 == 3'b000) ctrl.branch = brEq;
                else if (funct3 == 3'b001) ctrl.branch = brNe;
            end
            default: ;
        endcase
    end

    // halt is sticky until reset
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= running;
        end else if (state == running && isEbreak) begin
            state <= halted;
        end
    end

    assign halt  = (state == halted);
    assign regWe = ctrl.regWrite && !halt && (instr[11:7] != 5'd0);  // x0 never written

endmodule

`default_nettype wire

/* verilog/immGen.sv */
`default_nettype none

module immGen import rvCorePkg::*; (
    input  wire wordT   instr,
    input  wire immSelT immSel,
    output wordT        imm
);

    always_comb begin
        case (immSel)
            immI: imm = {{20{instr[31]}}, instr[31:20]};
            immU: imm = {instr[31:12], 12'd0};
            immB: begin
                imm = {{19{instr[31]}}, instr[31], instr[7],
                       instr[30:25], instr[11:8], 1'b0};
            end
            immJ: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12],
                       instr[20], instr[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/regFile.sv */
`default_nettype none

module regFile import rvCorePkg::*; (
    input  wire logic    clk,
    input  wire logic    rstN,
    input  wire logic    we,
    input  wire regAddrT rs1,
    input  wire regAddrT rs2,
    input  wire regAddrT rd,
    input  wire wordT    wdata,
    output wordT         rs1Data,
    output wordT         rs2Data
);

    wordT regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) regs[i] <= '0;
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 reads as zero
    assign rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* verilog/aluUnit.sv */
`default_nettype none

module aluUnit import rvCorePkg::*; (
    input  wire ctrlT ctrl,
    input  wire wordT pc,
    input  wire wordT rs1Data,
    input  wire wordT rs2Data,
    input  wire wordT imm,
    output wordT      result,
    output logic      equal
);

    wordT opA;
    wordT opB;

    assign opA = ctrl.aluASel ? pc : rs1Data;

    always_comb begin
        case (ctrl.aluBSel)
            bFromImm: opB = imm;
            bFour:    opB = 32'd4;  // link address
            default:  opB = rs2Data;
        endcase
    end

    assign equal = (rs1Data == rs2Data);

    always_comb begin
        case (ctrl.aluOp)
            aluSub:   result = opA - opB;
            aluPassB: result = opB;
            aluEq:    result = {31'd0, equal};
            default:  result = opA + opB;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/nextPcUnit.sv */
`default_nettype none

module nextPcUnit import rvCorePkg::*; #(
    parameter wordT resetPc = 32'h8000_0000
) (
    input  wire logic   clk,
    input  wire logic   rstN,
    input  wire branchT branch,
    input  wire logic   hold,
    input  wire logic   equal,
    input  wire wordT   imm,
    input  wire wordT   rs1Data,
    output wordT        pc
);

    wordT pcNext;
    wordT pcSeq;
    wordT pcRel;
    wordT jalrTarget;

    assign pcSeq      = pc + 32'd4;
    assign pcRel      = pc + imm;
    assign jalrTarget = (rs1Data + imm) & ~32'd1;  // bit 0 cleared per ISA

    always_comb begin
        case (branch)
            brJal:   pcNext = pcRel;
            brJalr:  pcNext = jalrTarget;
            brEq:    pcNext = equal ? pcRel : pcSeq;
            brNe:    pcNext = equal ? pcSeq : pcRel;
            default: pcNext = pcSeq;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= resetPc;
        end else if (!hold) begin
            pc <= pcNext;
        end
    end

endmodule

`default_nettype wire

/* verilog/rvCore.sv */
`default_nettype none

module rvCore import rvCorePkg::*; #(
    parameter wordT resetPc = 32'h8000_0000
) (
    input  wire logic clk,
    input  wire logic rstN,
    input  wire wordT instr,
    output wordT      pc,
    output wbT        wb,
    output logic      halt
);

    ctrlT ctrl;
    logic regWe;
    regAddrT rs1, rs2, rd;
    wordT rs1Data, rs2Data;
    wordT imm;
    wordT result;
    logic equal;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    instDecoder uDecoder (
        .clk, .rstN, .instr,
        .ctrl, .regWe, .halt
    );

    immGen uImmGen (.instr, .immSel(ctrl.immSel), .imm);

    regFile uRegFile (
        .clk, .rstN, .we(regWe),
        .rs1, .rs2, .rd,
        .wdata(result), .rs1Data, .rs2Data
    );

    aluUnit uAlu (
        .ctrl, .pc, .rs1Data, .rs2Data, .imm,
        .result, .equal
    );

    nextPcUnit #(.resetPc(resetPc)) uNextPc (
        .clk, .rstN, .branch(ctrl.branch),
        .hold(halt),  // pc freezes once halted
        .equal, .imm, .rs1Data, .pc
    );

    assign wb = '{valid: regWe, rd: rd, data: result};

endmodule

`default_nettype wire

/* dv/rvCoreTb.sv */
`default_nettype none

module rvCoreTb import rvCorePkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam wordT resetPc    = 32'h8000_0000;
    localparam int   progLen    = 26;
    localparam int   numSegs    = 6;
    localparam int   watchdogNs = (progLen + 20) * 100;
    localparam wordT nop        = 32'h0000_0013;  // addi x0, x0, 0

    logic clk = 1'b0;
    logic rstN = 1'b0;
    wordT instr = nop;
    wordT pc;
    wbT   wb;
    logic halt;

    wordT  imem [progLen];
    int    segOf [progLen];
    int    segErrs [numSegs];
    string segNames [numSegs];
    int    segIdx = 0;
    int    fill = 0;
    int    seed = 34325;

    // shadow state of the ISA model
    wordT    mRegs [32];
    wordT    mPc;
    logic    mHalt;
    logic    expValid;
    regAddrT expRd;
    wordT    expData;
    wordT    expNextPc;
    logic    isEbreak;

    rvCore #(.resetPc(resetPc)) dut (.clk, .rstN, .instr, .pc, .wb, .halt);

    always #50 clk = ~clk;

    function automatic wordT iType(logic [6:0] op, regAddrT rd, regAddrT rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, op};
    endfunction

    function automatic wordT rType(logic [6:0] f7, regAddrT rd, regAddrT rs1, regAddrT rs2);
        return {f7, rs2, rs1, 3'b000, rd, 7'h33};
    endfunction

    function automatic wordT uType(logic [6:0] op, regAddrT rd, logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic wordT jType(regAddrT rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
    endfunction

    function automatic wordT bType(logic [2:0] f3, regAddrT rs1, regAddrT rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
    endfunction

    task automatic place(wordT w, int seg);
        imem[fill] = w;
        segOf[fill] = seg;
        fill++;
    endtask

    task automatic mismatch(string what, wordT expected, wordT actual);
        $display("** Error: test %s, %s expected %h actual %h",
                 segNames[segIdx], what, expected, actual);
        segErrs[segIdx]++;
    endtask

    task automatic printSegment(int s);
        $display("test %-10s %s, %0d errors", segNames[s],
                 (segErrs[s] == 0) ? "ok" : "FAILED", segErrs[s]);
    endtask

    // expected response of the current instruction
    always_comb begin
        wordT a;
        wordT b;
        wordT immI;
        wordT immU;
        wordT immJ;
        wordT immB;
        logic writes;
        a         = mRegs[instr[19:15]];
        b         = mRegs[instr[24:20]];
        immI      = {{20{instr[31]}}, instr[31:20]};
        immU      = {instr[31:12], 12'd0};
        immJ      = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        immB      = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        writes    = 1'b0;
        expData   = '0;
        expRd     = instr[11:7];
        expNextPc = mPc + 32'd4;
        isEbreak  = (instr == 32'h0010_0073);
        case (instr[6:0])
            7'h37: begin  // lui
                writes  = 1'b1;
                expData = immU;
            end
            7'h17: begin  // auipc
                writes  = 1'b1;
                expData = mPc + immU;
            end
            7'h6f: begin  // jal
                writes    = 1'b1;
                expData   = mPc + 32'd4;
                expNextPc = mPc + immJ;
            end
            7'h67: begin
                if (instr[14:12] == 3'b000) begin
                    writes    = 1'b1;
                    expData   = mPc + 32'd4;
                    expNextPc = (a + immI) & ~32'd1;
                end
            end
            7'h13: begin
                writes  = (instr[14:12] == 3'b000);
                expData = a + immI;
            end
            7'h33: begin
                if (instr[14:12] == 3'b000 && instr[31:25] == 7'h00) begin
                    writes  = 1'b1;
                    expData = a + b;
                end else if (instr[14:12] == 3'b000 && instr[31:25] == 7'h20) begin
                    writes  = 1'b1;
                    expData = a - b;
                end
            end
            7'h63: begin
                if ((instr[14:12] == 3'b000 && a == b) || (instr[14:12] == 3'b001 && a != b)) begin
                    expNextPc = mPc + immB;
                end
            end
            default: ;
        endcase
        expValid = writes && (expRd != 5'd0) && !mHalt;
    end

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) mRegs[i] <= '0;
            mPc   <= resetPc;
            mHalt <= 1'b0;
        end else if (!mHalt) begin
            if (expValid) mRegs[expRd] <= expData;
            mPc <= expNextPc;
            if (isEbreak) mHalt <= 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) pc == mPc)
        else mismatch("pc", $sampled(mPc), $sampled(pc));
    assert property (@(posedge clk) disable iff (!rstN) halt == mHalt)
        else mismatch("halt", {31'd0, $sampled(mHalt)}, {31'd0, $sampled(halt)});
    assert property (@(posedge clk) disable iff (!rstN) wb.valid == expValid)
        else mismatch("wb.valid", {31'd0, $sampled(expValid)}, {31'd0, $sampled(wb.valid)});
    assert property (@(posedge clk) disable iff (!rstN) !expValid || wb.rd == expRd)
        else mismatch("wb.rd", {27'd0, $sampled(expRd)}, {27'd0, $sampled(wb.rd)});
    assert property (@(posedge clk) disable iff (!rstN) !expValid || wb.data == expData)
        else mismatch("wb.data", $sampled(expData), $sampled(wb.data));

    // instruction memory, answers on the falling edge
    always @(negedge clk) begin
        wordT offset;
        int   idx;
        offset = pc - resetPc;
        idx    = int'(offset[31:2]);
        if (offset < wordT'(progLen * 4)) begin
            instr = imem[idx];
            if (segOf[idx] != segIdx) begin
                printSegment(segIdx);
                segIdx = segOf[idx];
            end
        end else begin
            instr = nop;
        end
    end

    initial begin
        #(watchdogNs);
        $display("Timeout: the core did not halt before the watchdog expired");
        $display("Checks failed");
        $finish;
    end

    initial begin
        wordT rnd1;
        wordT rnd2;
        wordT rnd3;
        wordT rnd4;
        int   totalErrs;
        int   failedTests;
        segNames = '{"upper_imm", "reg_alu", "x0_dest", "jumps", "branches", "halt"};
        rnd1 = $random(seed);
        rnd2 = $random(seed);
        rnd3 = $random(seed);
        rnd4 = $random(seed);
        place(iType(7'h13, 5'd1, 5'd0, {rnd1[11:1], 1'b1}), 0);  // odd, never zero
        place(iType(7'h13, 5'd2, 5'd1, rnd2[11:0]), 0);
        place(uType(7'h37, 5'd3, rnd3[19:0]), 0);
        place(uType(7'h17, 5'd4, rnd4[19:0]), 0);
        place(rType(7'h00, 5'd5, 5'd1, 5'd2), 1);
        place(rType(7'h20, 5'd6, 5'd3, 5'd5), 1);
        place(rType(7'h00, 5'd7, 5'd6, 5'd4), 1);
        place(iType(7'h13, 5'd0, 5'd1, 12'd5), 2);
        place(rType(7'h00, 5'd8, 5'd0, 5'd2), 2);
        place(rType(7'h00, 5'd0, 5'd1, 5'd2), 2);
        place(rType(7'h20, 5'd9, 5'd0, 5'd1), 2);  // x9 = -x1
        place(jType(5'd10, 21'd8), 3);
        place(iType(7'h13, 5'd11, 5'd0, 12'd1), 3);  // skipped
        place(uType(7'h17, 5'd12, 20'd0), 3);
        place(iType(7'h67, 5'd13, 5'd12, 12'd13), 3);  // odd target, lands 3 ahead
        place(iType(7'h13, 5'd11, 5'd0, 12'd2), 3);
        place(bType(3'b000, 5'd1, 5'd1, 13'd8), 4);
        place(iType(7'h13, 5'd11, 5'd0, 12'd3), 4);
        place(bType(3'b000, 5'd1, 5'd9, 13'd8), 4);
        place(bType(3'b001, 5'd1, 5'd9, 13'd8), 4);
        place(iType(7'h13, 5'd11, 5'd0, 12'd4), 4);
        place(bType(3'b001, 5'd2, 5'd8, 13'd8), 4);
        place(iType(7'h13, 5'd14, 5'd0, 12'd7), 4);
        place(32'h0010_0073, 5);  // ebreak
        place(iType(7'h13, 5'd15, 5'd0, 12'd1), 5);
        place(iType(7'h13, 5'd16, 5'd0, 12'd2), 5);

        repeat (8) @(negedge clk);
        rstN = 1'b1;
        while (!halt) @(negedge clk);
        repeat (6) @(negedge clk);  // memory keeps offering writes while halted
        printSegment(segIdx);

        totalErrs   = 0;
        failedTests = 0;
        for (int s = 0; s < numSegs; s++) begin
            totalErrs += segErrs[s];
            if (segErrs[s] != 0) failedTests++;
        end
        $display("%0d tests, %0d failed, %0d errors", numSegs, failedTests, totalErrs);
        if (totalErrs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rvCore.f */
verilog/rvCorePkg.sv
verilog/instDecoder.sv
verilog/immGen.sv
verilog/regFile.sv
verilog/aluUnit.sv
verilog/nextPcUnit.sv
verilog/rvCore.sv
dv/rvCoreTb.sv

/* run.sh */
#!/bin/sh
# build the rvCore testbench with Verilator, run it, then grep the log
rm -f sim.log
verilator --binary --timing --assert --top-module rvCoreTb -f rvCore.f \
    --Mdir obj_dir -o rvCoreSim > sim.log 2>&1 &&
    ./obj_dir/rvCoreSim >> sim.log 2>&1
cat sim.log
grep -qx "All checks passed" sim.log && exit 0 || exit 1
